// File: Bender.yml
package:
  name: fbdev

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fb_pkg.sv
      - verilog/fb_cmd_regs.sv
      - verilog/fb_fetch.sv
      - verilog/px_fifo.sv
      - verilog/rle_expander.sv
      - verilog/vga_scanout.sv
      - verilog/fbdev_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clkgen.sv
      - bench/tb_fbdev.sv

// File: bench/tb_clkgen.sv
////////////////////
// Testbench clock.
////////////////////

`timescale 1ns/1ps

module tb_clkgen #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk_o
);

initial clk_o = 1'b0;

always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: bench/tb_fbdev.sv
////////////////////
// Framebuffer testbench.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module tb_fbdev import fb_pkg::*; ();

localparam int     FRAME     = `FB_H_TOTAL * `FB_V_TOTAL;
localparam int     N_TESTS   = 8;
localparam int     TIMEOUT   = N_TESTS * 20 + 4 * FRAME + 200;
localparam int     IMG_WORDS = 12;
localparam waddr_t BASE      = 30'h0000_1200;

typedef enum logic [1:0] {
	POST_IDLE,
	POST_VIDEO,
	POST_OFF
} post_e;

typedef struct packed {
	cmd_e        op;
	logic [29:0] arg;
	word_t       rsp;
	logic [3:0]  hold;   // Cycles with rsp_ready_i low.
	post_e       post;
} test_t;

logic     clk_i;
logic     rst_i;
logic     cmd_valid_i;
cmd_req_t cmd_i;
logic     cmd_ready_o;
logic     rsp_valid_o;
word_t    rsp_data_o;
logic     rsp_ready_i;
logic     vga_rst_o;
logic     mem_req_valid_o;
waddr_t   mem_addr_o;
logic     mem_req_ready_i;
logic     mem_rsp_valid_i;
word_t    mem_rsp_data_i;
color_t   vga_red_o;
color_t   vga_green_o;
color_t   vga_blue_o;
logic     vga_hsync_o;
logic     vga_vsync_o;
logic     vga_blank_o;
logic     underrun_o;

test_t  tests [N_TESTS];
string  names [N_TESTS];
int     run_tab [IMG_WORDS] = '{0, 3, 7, 0, 1, 15, 2, 0, 5, 9, 4, 6}; // Sums to one frame.
word_t  image [IMG_WORDS];
pixel_t exp_px [`FB_PXCNT];
waddr_t rq_addr [$];
int     rq_due [$];
integer seed;
int     mem_cyc;
int     cycles = 0;
int     test_err;
int     err_cnt;
int     fail_cnt;
string  cur_name;

tb_clkgen #(.PERIOD_NS(8.0)) u_clkgen (.clk_o(clk_i));

fbdev_top dut (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.cmd_valid_i     (cmd_valid_i),
	.cmd_i           (cmd_i),
	.cmd_ready_o     (cmd_ready_o),
	.rsp_valid_o     (rsp_valid_o),
	.rsp_data_o      (rsp_data_o),
	.rsp_ready_i     (rsp_ready_i),
	.vga_rst_o       (vga_rst_o),
	.mem_req_valid_o (mem_req_valid_o),
	.mem_addr_o      (mem_addr_o),
	.mem_req_ready_i (mem_req_ready_i),
	.mem_rsp_valid_i (mem_rsp_valid_i),
	.mem_rsp_data_i  (mem_rsp_data_i),
	.vga_red_o       (vga_red_o),
	.vga_green_o     (vga_green_o),
	.vga_blue_o      (vga_blue_o),
	.vga_hsync_o     (vga_hsync_o),
	.vga_vsync_o     (vga_vsync_o),
	.vga_blank_o     (vga_blank_o),
	.underrun_o      (underrun_o)
);

task automatic expect_eq(input string label, input word_t exp, input word_t act);
	assert (act === exp) else begin
		$display("Fail %s %s: expected 0x%0h, actual 0x%0h", cur_name, label, exp, act);
		test_err++;
	end
endtask

task automatic expect_true(input logic cond, input string what);
	assert (cond) else begin
		$display("Error in %s: %s", cur_name, what);
		test_err++;
	end
endtask

task automatic add_test(input int idx, input string name, input cmd_e op,
		input logic [29:0] arg, input word_t rsp, input logic [3:0] hold, input post_e post);
	names[idx]      = name;
	tests[idx].op   = op;
	tests[idx].arg  = arg;
	tests[idx].rsp  = rsp;
	tests[idx].hold = hold;
	tests[idx].post = post;
endtask

task automatic fill_table();
	add_test(0, "info_width",   CMD_GETINFO, 30'd0, 32'd16, 4'd0, POST_IDLE);
	add_test(1, "info_height",  CMD_GETINFO, 30'd1, 32'd4,  4'd0, POST_IDLE);
	add_test(2, "info_hz",      CMD_GETINFO, 30'd2, 32'd60, 4'd0, POST_IDLE);
	add_test(3, "info_bufcnt",  CMD_GETINFO, 30'd3, 32'd1,  4'd0, POST_IDLE);
	add_test(4, "info_unknown", CMD_GETINFO, 30'd9, 32'd0,  4'd0, POST_IDLE);
	add_test(5, "rsp_hold",     CMD_GETINFO, 30'd2, 32'd60, 4'd5, POST_IDLE);
	add_test(6, "srcset_video", CMD_SRCSET,  BASE,  32'd4,  4'd0, POST_VIDEO);
	add_test(7, "srcset_off",   CMD_SRCSET,  '1,    32'd4,  4'd0, POST_OFF);
endtask

task automatic load_image();
	int w;
	int r;
	int k;
	for (w = 0; w < IMG_WORDS; w++)
		image[w] = {8'(run_tab[w]), 8'(w * 21), 8'(255 - w * 8), 8'(16 + w * 16)};
	// Each word covers run plus one pixels.
	k = 0;
	for (w = 0; w < IMG_WORDS && k < `FB_PXCNT; w++)
		for (r = 0; r <= int'(image[w][31:24]) && k < `FB_PXCNT; r++) begin
			exp_px[k].red   = image[w][7:0];
			exp_px[k].green = image[w][15:8];
			exp_px[k].blue  = image[w][23:16];
			k++;
		end
endtask

function automatic word_t mem_word(input waddr_t addr);
	waddr_t off;
	off = addr - BASE;
	if (off < IMG_WORDS)
		return image[off];
	return {2'b10, ~addr}; // Filler past the image.
endfunction

// Called and returning on a falling edge.
task automatic run_cmd(input test_t t);
	word_t held;
	int    k;
	cmd_valid_i = 1'b1;
	cmd_i.op    = t.op;
	cmd_i.arg   = t.arg;
	rsp_ready_i = (t.hold == 0);
	while (cmd_ready_o !== 1'b1)
		@(negedge clk_i);
	@(negedge clk_i);
	cmd_valid_i = 1'b0;
	expect_true(rsp_valid_o === 1'b1, "no response in the cycle after the command was taken");
	expect_eq("response", t.rsp, rsp_data_o);
	if (t.op == CMD_SRCSET)
		expect_eq("vga_rst_o", word_t'(&t.arg), word_t'(vga_rst_o));
	held = rsp_data_o;
	for (k = 0; k < int'(t.hold); k++) begin
		@(negedge clk_i);
		expect_true(rsp_valid_o === 1'b1 && rsp_data_o === held,
			"response changed while it was held");
		expect_true(cmd_ready_o === 1'b0, "command port ready while a response was waiting");
	end
	rsp_ready_i = 1'b1;
	@(negedge clk_i);
	expect_true(rsp_valid_o === 1'b0, "response was not taken");
endtask

task automatic watch_idle();
	repeat (4) begin
		expect_true(vga_rst_o === 1'b1, "vga_rst_o low before a source was set");
		expect_true({vga_hsync_o, vga_vsync_o, vga_blank_o, mem_req_valid_o} === 4'b0,
			"video or memory activity before a source was set");
		@(negedge clk_i);
	end
endtask

task automatic watch_off();
	repeat (2 * `FB_H_TOTAL) begin
		expect_true(vga_rst_o === 1'b1, "vga_rst_o low after the display was disabled");
		expect_true(mem_req_valid_o === 1'b0, "memory request after the display was disabled");
		@(negedge clk_i);
	end
endtask

task automatic check_video();
	int     f;
	int     line;
	int     h;
	int     hs_cnt;
	int     vs_cnt;
	int     act_cnt;
	pixel_t got;
	// First frame is dark while the scanout waits for data.
	repeat (FRAME) @(negedge clk_i);
	for (f = 0; f < 2; f++) begin
		vs_cnt  = 0;
		act_cnt = 0;
		for (line = 0; line < `FB_V_TOTAL; line++) begin
			hs_cnt = 0;
			for (h = 0; h < `FB_H_TOTAL; h++) begin
				if (vga_hsync_o === 1'b1)
					hs_cnt++;
				if (vga_vsync_o === 1'b1)
					vs_cnt++;
				if (vga_blank_o === 1'b0) begin
					got.red   = vga_red_o;
					got.green = vga_green_o;
					got.blue  = vga_blue_o;
					if (act_cnt < `FB_PXCNT)
						expect_eq($sformatf("frame %0d pixel %0d", f, act_cnt),
							word_t'(exp_px[act_cnt]), word_t'(got));
					act_cnt++;
				end
				@(negedge clk_i);
			end
			expect_eq("hsync cycles per line", `FB_H_SYNC_END - `FB_H_SYNC_START, hs_cnt);
		end
		expect_eq("vsync cycles per frame",
			(`FB_V_SYNC_END - `FB_V_SYNC_START) * `FB_H_TOTAL, vs_cnt);
		expect_eq("active cycles per frame", `FB_PXCNT, act_cnt);
	end
	expect_eq("underrun_o", 0, word_t'(underrun_o));
endtask

// In-order memory with random stalls and latency.
initial begin
	logic ready_d;
	int   due;
	seed            = 32'hb5b9;
	mem_cyc         = 0;
	mem_req_ready_i = 1'b0;
	mem_rsp_valid_i = 1'b0;
	mem_rsp_data_i  = '0;
	forever begin
		@(negedge clk_i);
		mem_cyc++;
		mem_rsp_valid_i = 1'b0;
		if (vga_rst_o !== 1'b0) begin
			rq_addr.delete(); // Reads in flight die with the display.
			rq_due.delete();
		end else if (rq_due.size() > 0 && rq_due[0] <= mem_cyc) begin
			mem_rsp_valid_i = 1'b1;
			mem_rsp_data_i  = mem_word(rq_addr.pop_front());
			void'(rq_due.pop_front());
		end
		ready_d = ($random(seed) & 3) != 0;
		if (vga_rst_o === 1'b0 && mem_req_valid_o === 1'b1 && ready_d) begin
			due = mem_cyc + 1 + ($random(seed) & 3);
			if (rq_due.size() > 0 && due <= rq_due[$])
				due = rq_due[$] + 1;
			rq_addr.push_back(mem_addr_o);
			rq_due.push_back(due);
		end
		mem_req_ready_i = ready_d;
	end
end

always @(posedge clk_i) begin
	cycles <= cycles + 1;
	if (cycles >= TIMEOUT) begin
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
		$display("** FAIL **");
		$finish;
	end
end

initial begin
	int i;
	rst_i       = 1'b1;
	cmd_valid_i = 1'b0;
	cmd_i       = '0;
	rsp_ready_i = 1'b1;
	err_cnt     = 0;
	fail_cnt    = 0;
	fill_table();
	load_image();
	repeat (10) @(negedge clk_i);
	rst_i = 1'b0;
	for (i = 0; i < N_TESTS; i++) begin
		cur_name = names[i];
		test_err = 0;
		run_cmd(tests[i]);
		case (tests[i].post)
		POST_IDLE:  watch_idle();
		POST_VIDEO: check_video();
		POST_OFF:   watch_off();
		default:    watch_idle();
		endcase
		if (test_err == 0) begin
			$display("%-14s ok", cur_name);
		end else begin
			$display("%-14s failed with %0d errors", cur_name, test_err);
			fail_cnt++;
		end
		err_cnt += test_err;
	end
	$display("%0d tests, %0d passed, %0d failed, %0d errors",
		N_TESTS, N_TESTS - fail_cnt, fail_cnt, err_cnt);
	if (err_cnt == 0)
		$display("** PASS **");
	else
		$display("** FAIL **");
	$finish;
end

endmodule

// File: include/fb_params.svh
////////////////////
// Display mode and sizing.
////////////////////

`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// Horizontal timing, in pixel clocks.
`define FB_H_ACTIVE       16
`define FB_H_SYNC_START   18
`define FB_H_SYNC_END     20
`define FB_H_TOTAL        24

// Vertical timing, in lines.
`define FB_V_ACTIVE       4
`define FB_V_SYNC_START   5
`define FB_V_SYNC_END     6
`define FB_V_TOTAL        8

`define FB_REFRESH        60
`define FB_BUFCNT         1   // Single buffer.

`define FB_PXCNT          (`FB_H_ACTIVE * `FB_V_ACTIVE)

`define FB_FIFO_DEPTH     16  // In words.
`define FB_BYTES_PER_WORD 4

`endif

// File: list.f
+incdir+include
verilog/fb_pkg.sv
verilog/fb_cmd_regs.sv
verilog/fb_fetch.sv
verilog/px_fifo.sv
verilog/rle_expander.sv
verilog/vga_scanout.sv
verilog/fbdev_top.sv
bench/tb_clkgen.sv
bench/tb_fbdev.sv

// File: verilog/fb_cmd_regs.sv
////////////////////
// Command registers.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module fb_cmd_regs import fb_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     cmd_valid_i,
	input  cmd_req_t cmd_i,
	output logic     cmd_ready_o,
	output logic     rsp_valid_o,
	output word_t    rsp_data_o,
	input  logic     rsp_ready_i,
	output waddr_t   base_addr_o,
	output logic     vga_rst_o
);

logic   cmd_fire;
logic   rsp_valid_q;
word_t  rsp_data_q;
word_t  rsp_data_d;
waddr_t base_q;
logic   base_valid_q;
logic   base_valid_d;
logic   vga_rst_q;

assign cmd_ready_o = !rsp_valid_q; // One command in flight.
assign cmd_fire    = cmd_valid_i && cmd_ready_o;

always_comb begin
	rsp_data_d = '0;
	case (cmd_i.op)
	CMD_SRCSET: rsp_data_d = word_t'(`FB_BYTES_PER_WORD);
	CMD_GETINFO: begin
		case (info_e'(cmd_i.arg))
		INFO_WIDTH:  rsp_data_d = word_t'(`FB_H_ACTIVE);
		INFO_HEIGHT: rsp_data_d = word_t'(`FB_V_ACTIVE);
		INFO_HZ:     rsp_data_d = word_t'(`FB_REFRESH);
		INFO_BUFCNT: rsp_data_d = word_t'(`FB_BUFCNT);
		default:     rsp_data_d = '0;
		endcase
	end
	default: rsp_data_d = '0;
	endcase
end

// All ones turns the display off.
always_comb begin
	base_valid_d = base_valid_q;
	if (cmd_fire && cmd_i.op == CMD_SRCSET)
		base_valid_d = !(&cmd_i.arg);
end

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		rsp_valid_q  <= 1'b0;
		base_valid_q <= 1'b0;
	end else begin
		if (cmd_fire)
			rsp_valid_q <= 1'b1;
		else if (rsp_ready_i)
			rsp_valid_q <= 1'b0;
		base_valid_q <= base_valid_d;
	end
end

always_ff @(posedge clk_i) begin
	if (cmd_fire)
		rsp_data_q <= rsp_data_d;
	if (cmd_fire && cmd_i.op == CMD_SRCSET)
		base_q <= cmd_i.arg;
end

always_ff @(posedge clk_i)
	vga_rst_q <= rst_i || !base_valid_d;

assign rsp_valid_o = rsp_valid_q;
assign rsp_data_o  = rsp_data_q;
assign base_addr_o = base_q;
assign vga_rst_o   = vga_rst_q;

endmodule

// File: verilog/fb_fetch.sv
////////////////////
// Frame fetch engine.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module fb_fetch import fb_pkg::*; (
	input  logic      clk_i,
	input  logic      vga_rst_i,
	input  waddr_t    base_addr_i,
	output logic      mem_req_valid_o,
	output waddr_t    mem_addr_o,
	input  logic      mem_req_ready_i,
	input  logic      mem_rsp_valid_i,
	input  word_t     mem_rsp_data_i,
	input  level_t    fifo_level_i,
	output logic      fifo_wr_o,
	output rle_word_t fifo_data_o
);

fetch_st_e st_q;
waddr_t    addr_q;
level_t    out_q;    // Reads in flight.
logic      pend_q;   // Request raised, not yet taken.
pos_t      pxcnt_q;
pos_t      pxcnt_d;
logic [$bits(level_t):0] credit_sum;
logic      credit_ok;
logic      req_fire;
logic      rsp_keep;
logic      frame_done;
logic      wrap_exit;

// Level plus in-flight never grows while a request waits.
assign credit_sum = fifo_level_i + out_q;
assign credit_ok  = credit_sum < `FB_FIFO_DEPTH;

assign mem_req_valid_o = credit_ok && (st_q == RUN || pend_q);
assign mem_addr_o      = addr_q;
assign req_fire        = mem_req_valid_o && mem_req_ready_i;

// Words past the frame end are dropped in WRAP.
assign rsp_keep    = mem_rsp_valid_i && st_q == RUN;
assign fifo_wr_o   = rsp_keep;
assign fifo_data_o = rle_word_t'(mem_rsp_data_i);

assign pxcnt_d    = pxcnt_q + pos_t'(fifo_data_o.run) + 1'b1;
assign frame_done = rsp_keep && pxcnt_d >= `FB_PXCNT;
assign wrap_exit  = st_q == WRAP && out_q == '0 && !mem_req_valid_o;

always_ff @(posedge clk_i) begin
	if (vga_rst_i) begin
		st_q    <= IDLE;
		out_q   <= '0;
		pend_q  <= 1'b0;
		pxcnt_q <= '0;
	end else begin
		out_q  <= out_q + level_t'(req_fire) - level_t'(mem_rsp_valid_i);
		pend_q <= mem_req_valid_o && !mem_req_ready_i;
		case (st_q)
		IDLE: st_q <= RUN;
		RUN: begin
			if (frame_done) begin
				st_q    <= WRAP;
				pxcnt_q <= '0;
			end else if (rsp_keep) begin
				pxcnt_q <= pxcnt_d;
			end
		end
		WRAP: if (wrap_exit) st_q <= RUN; // Drained, back to base.
		default: st_q <= IDLE;
		endcase
	end
end

always_ff @(posedge clk_i) begin
	if (st_q == IDLE || wrap_exit)
		addr_q <= base_addr_i;
	else if (req_fire)
		addr_q <= addr_q + 1'b1;
end

// Credits keep the FIFO from ever being written while full.
a_wr_not_full: assert property (@(posedge clk_i) disable iff (vga_rst_i)
	fifo_wr_o |-> fifo_level_i < `FB_FIFO_DEPTH);

endmodule

// File: verilog/fb_pkg.sv
////////////////////
// Framebuffer types.
////////////////////

package fb_pkg;

`include "fb_params.svh"

typedef logic [31:0] word_t;
typedef logic [29:0] waddr_t;
typedef logic [11:0] pos_t;
typedef logic [7:0]  run_t;
typedef logic [7:0]  color_t;

// Room for a level of 0 up to a full FIFO.
typedef logic [$clog2(`FB_FIFO_DEPTH + 1) - 1:0] level_t;

typedef struct packed {
	color_t blue;
	color_t green;
	color_t red;
} pixel_t;

typedef enum logic [1:0] {
	CMD_SRCSET  = 2'd0,
	CMD_GETINFO = 2'd1
} cmd_e;

typedef struct packed {
	logic [29:0] arg;
	cmd_e        op;   // Low bits.
} cmd_req_t;

typedef enum logic [29:0] {
	INFO_WIDTH  = 30'd0,
	INFO_HEIGHT = 30'd1,
	INFO_HZ     = 30'd2,
	INFO_BUFCNT = 30'd3
} info_e;

// Red sits in the low byte, run count on top.
typedef struct packed {
	run_t   run;
	color_t blue;
	color_t green;
	color_t red;
} rle_word_t;

typedef enum logic [1:0] {
	IDLE,
	RUN,
	WRAP
} fetch_st_e;

endpackage

// File: verilog/fbdev_top.sv
////////////////////
// Framebuffer top.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module fbdev_top import fb_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     cmd_valid_i,
	input  cmd_req_t cmd_i,
	output logic     cmd_ready_o,
	output logic     rsp_valid_o,
	output word_t    rsp_data_o,
	input  logic     rsp_ready_i,
	output logic     vga_rst_o,
	output logic     mem_req_valid_o,
	output waddr_t   mem_addr_o,
	input  logic     mem_req_ready_i,
	input  logic     mem_rsp_valid_i,
	input  word_t    mem_rsp_data_i,
	output color_t   vga_red_o,
	output color_t   vga_green_o,
	output color_t   vga_blue_o,
	output logic     vga_hsync_o,
	output logic     vga_vsync_o,
	output logic     vga_blank_o,
	output logic     underrun_o
);

waddr_t    base_addr;
level_t    fifo_level;
logic      fifo_wr;
rle_word_t fifo_wdata;
logic      word_valid;
rle_word_t word;
logic      word_ready;
logic      px_valid;
pixel_t    px;
logic      px_ready;

fb_cmd_regs u_cmd_regs (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.cmd_valid_i (cmd_valid_i),
	.cmd_i       (cmd_i),
	.cmd_ready_o (cmd_ready_o),
	.rsp_valid_o (rsp_valid_o),
	.rsp_data_o  (rsp_data_o),
	.rsp_ready_i (rsp_ready_i),
	.base_addr_o (base_addr),
	.vga_rst_o   (vga_rst_o)
);

fb_fetch u_fetch (
	.clk_i           (clk_i),
	.vga_rst_i       (vga_rst_o),
	.base_addr_i     (base_addr),
	.mem_req_valid_o (mem_req_valid_o),
	.mem_addr_o      (mem_addr_o),
	.mem_req_ready_i (mem_req_ready_i),
	.mem_rsp_valid_i (mem_rsp_valid_i),
	.mem_rsp_data_i  (mem_rsp_data_i),
	.fifo_level_i    (fifo_level),
	.fifo_wr_o       (fifo_wr),
	.fifo_data_o     (fifo_wdata)
);

px_fifo u_fifo (
	.clk_i      (clk_i),
	.vga_rst_i  (vga_rst_o),
	.wr_i       (fifo_wr),
	.wr_data_i  (fifo_wdata),
	.rd_valid_o (word_valid),
	.rd_data_o  (word),
	.rd_ready_i (word_ready),
	.level_o    (fifo_level)
);

rle_expander u_expander (
	.clk_i        (clk_i),
	.vga_rst_i    (vga_rst_o),
	.word_valid_i (word_valid),
	.word_i       (word),
	.word_ready_o (word_ready),
	.px_valid_o   (px_valid),
	.px_o         (px),
	.px_ready_i   (px_ready)
);

vga_scanout u_scanout (
	.clk_i       (clk_i),
	.vga_rst_i   (vga_rst_o),
	.px_valid_i  (px_valid),
	.px_i        (px),
	.px_ready_o  (px_ready),
	.vga_red_o   (vga_red_o),
	.vga_green_o (vga_green_o),
	.vga_blue_o  (vga_blue_o),
	.vga_hsync_o (vga_hsync_o),
	.vga_vsync_o (vga_vsync_o),
	.vga_blank_o (vga_blank_o),
	.underrun_o  (underrun_o)
);

endmodule

// File: verilog/px_fifo.sv
////////////////////
// Pixel word FIFO.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module px_fifo import fb_pkg::*; (
	input  logic      clk_i,
	input  logic      vga_rst_i,
	input  logic      wr_i,
	input  rle_word_t wr_data_i,
	output logic      rd_valid_o,
	output rle_word_t rd_data_o,
	input  logic      rd_ready_i,
	output level_t    level_o
);

localparam int AW = $clog2(`FB_FIFO_DEPTH);

rle_word_t      mem_q [`FB_FIFO_DEPTH];
logic [AW-1:0]  wptr_q;
logic [AW-1:0]  rptr_q;
level_t         level_q;
logic           rd_fire;

assign rd_valid_o = level_q != '0;
assign rd_data_o  = mem_q[rptr_q];
assign rd_fire    = rd_valid_o && rd_ready_i;
assign level_o    = level_q;

always_ff @(posedge clk_i) begin
	if (vga_rst_i) begin
		wptr_q  <= '0;
		rptr_q  <= '0;
		level_q <= '0;
	end else begin
		if (wr_i)
			wptr_q <= (wptr_q == AW'(`FB_FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
		if (rd_fire)
			rptr_q <= (rptr_q == AW'(`FB_FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
		level_q <= level_q + level_t'(wr_i) - level_t'(rd_fire);
	end
end

always_ff @(posedge clk_i)
	if (wr_i) mem_q[wptr_q] <= wr_data_i;

a_no_overflow: assert property (@(posedge clk_i) disable iff (vga_rst_i)
	wr_i |-> level_q < `FB_FIFO_DEPTH || rd_fire);

// Consumer only acknowledges a word it was shown.
a_no_empty_read: assert property (@(posedge clk_i) disable iff (vga_rst_i)
	rd_ready_i |-> rd_valid_o);

endmodule

// File: verilog/rle_expander.sv
////////////////////
// Run expander.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module rle_expander import fb_pkg::*; (
	input  logic      clk_i,
	input  logic      vga_rst_i,
	input  logic      word_valid_i,
	input  rle_word_t word_i,
	output logic      word_ready_o,
	output logic      px_valid_o,
	output pixel_t    px_o,
	input  logic      px_ready_i
);

run_t rep_q;   // Pixels already sent from this word.
logic last_rep;
logic px_fire;

assign last_rep = rep_q == word_i.run;
assign px_fire  = px_valid_o && px_ready_i;

assign px_valid_o   = word_valid_i;
assign px_o.red     = word_i.red;
assign px_o.green   = word_i.green;
assign px_o.blue    = word_i.blue;

// Pop as the final copy goes out.
assign word_ready_o = px_fire && last_rep;

always_ff @(posedge clk_i) begin
	if (vga_rst_i)
		rep_q <= '0;
	else if (px_fire)
		rep_q <= last_rep ? '0 : rep_q + 1'b1;
end

endmodule

// File: verilog/vga_scanout.sv
////////////////////
// VGA scanout.
////////////////////

`timescale 1ns/1ps

`include "fb_params.svh"

module vga_scanout import fb_pkg::*; (
	input  logic   clk_i,
	input  logic   vga_rst_i,
	input  logic   px_valid_i,
	input  pixel_t px_i,
	output logic   px_ready_o,
	output color_t vga_red_o,
	output color_t vga_green_o,
	output color_t vga_blue_o,
	output logic   vga_hsync_o,
	output logic   vga_vsync_o,
	output logic   vga_blank_o,
	output logic   underrun_o
);

pos_t   h_q;
pos_t   v_q;
logic   h_last;
logic   v_last;
logic   active;
logic   frame_start;
logic   started_q;
logic   live;
pixel_t px_d;

assign h_last      = h_q == pos_t'(`FB_H_TOTAL - 1);
assign v_last      = v_q == pos_t'(`FB_V_TOTAL - 1);
assign active      = h_q < `FB_H_ACTIVE && v_q < `FB_V_ACTIVE;
assign frame_start = h_q == '0 && v_q == '0;

// Lock onto the first frame that has data ready.
assign live       = started_q || (frame_start && px_valid_i);
assign px_ready_o = active && live;

assign px_d = (px_ready_o && px_valid_i) ? px_i : '0; // Black on underrun.

always_ff @(posedge clk_i) begin
	if (vga_rst_i) begin
		h_q         <= '0;
		v_q         <= '0;
		started_q   <= 1'b0;
		vga_hsync_o <= 1'b0;
		vga_vsync_o <= 1'b0;
		vga_blank_o <= 1'b0;
		underrun_o  <= 1'b0;
	end else begin
		if (h_last) begin
			h_q <= '0;
			v_q <= v_last ? '0 : v_q + 1'b1;
		end else begin
			h_q <= h_q + 1'b1;
		end
		if (frame_start && px_valid_i)
			started_q <= 1'b1;
		vga_hsync_o <= h_q >= `FB_H_SYNC_START && h_q < `FB_H_SYNC_END;
		vga_vsync_o <= v_q >= `FB_V_SYNC_START && v_q < `FB_V_SYNC_END;
		vga_blank_o <= !active;
		if (px_ready_o && !px_valid_i)
			underrun_o <= 1'b1; // Sticky.
	end
end

always_ff @(posedge clk_i) begin
	vga_red_o   <= px_d.red;
	vga_green_o <= px_d.green;
	vga_blue_o  <= px_d.blue;
end

// Upstream holds a pixel until the scanout takes it.
a_px_stable: assert property (@(posedge clk_i) disable iff (vga_rst_i)
	px_valid_i && !px_ready_o |=> px_valid_i && $stable(px_i));

endmodule
